/* vlog.f */
hdl/tankPkg.sv
hdl/tankMoveCheck.sv
hdl/missileHitCheck.sv
hdl/hitArbiter.sv
hdl/collisionTop.sv
bench/collisionTb_asserts.sv
bench/collisionTb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing --assert
TOP       := collisionTb
FILELIST  := vlog.f
OBJDIR    := obj_dir
LOG       := sim.log
RUNFLAGS  := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/collisionTb.sv */
`timescale 1ns/1ps
`default_nettype none

module collisionTb;
	import tankPkg::*;

	localparam int runLimit  = 2000;    // Cycles before the watchdog fires
	localparam int waitLimit = 20;

	// Tank spots around wall 0, four flush, four one pixel off, four sliding past
	localparam int spotX [12] = '{210, 210, 241, 183, 210, 210, 242, 182, 240, 184, 241, 183};
	localparam int spotY [12] = '{221, 183, 202, 202, 222, 182, 202, 202, 221, 183, 220, 184};
	// Missile offset from a 16 pixel target, indexed by direction
	localparam int missDx [4] = '{4, 17, 4, -9};
	localparam int missDy [4] = '{17, 0, -17, 0};
	localparam logic [7:0] moveKeys [5] = '{keyUp, keyDown, keyLeft, keyRight, 8'h29};

	logic        Clk = 1'b0;
	logic        rstN;
	logic [7:0]  keycode;
	pointT       tankPos;
	pointT       enemyPos;
	wallSetT     walls;
	pointT       missilePos;
	dirT         missileDir;
	statusT      status;

	logic [31:0] lcgState = 32'd87825;
	string       testName;
	int          testChecks;
	int          testErrors;
	int          totalChecks;
	int          totalErrors;
	int          assertFails;

	collisionTop i_dut
	(
		.Clk        (Clk),
		.rstN       (rstN),
		.keycode    (keycode),
		.tankPos    (tankPos),
		.enemyPos   (enemyPos),
		.walls      (walls),
		.missilePos (missilePos),
		.missileDir (missileDir),
		.status     (status)
	);

	bind collisionTop collisionTbAsserts u_asserts
	(
		.Clk        (Clk),
		.rstN       (rstN),
		.keycode    (keycode),
		.missilePos (missilePos),
		.status     (status)
	);

	always #50 Clk = ~Clk;

	function automatic int lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return int'(lcgState[30:16]);
	endfunction

	function automatic coordT randCoord(input int lo, input int hi);
		return coordT'(lo + lcgNext() % (hi - lo + 1));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model, move and missile rules on the driven inputs
	//////////////////////////////////////////////////////////////////////

	function automatic statusT expectStatus();
		statusT s;
		rectT r;
		int tx;
		int ty;
		int mx;
		int my;
		int ox;
		int oy;
		int oR;
		int oB;
		int rank;
		int best;
		logic xs;
		logic ys;
		logic xc;
		logic yc;
		logic hit;
		tx = int'(tankPos.x);
		ty = int'(tankPos.y);
		mx = int'(missilePos.x);
		my = int'(missilePos.y);
		s.tankBlocked = 1'b0;
		best = 0;
		for (int i = 0; i < wallCount + 2; i++)
		begin
			if (i < wallCount)
				r = walls[i];
			else if (i == wallCount)
				r = '{x: enemyPos.x, y: enemyPos.y, w: 10'd16, h: 10'd16};
			else
				r = '{x: baseX, y: baseY, w: baseSize, h: baseSize};
			ox = int'(r.x);
			oy = int'(r.y);
			oR = ox + int'(r.w);
			oB = oy + int'(r.h);
			xs = (tx < oR) && (tx + 16 > ox);    // Strict spans for the tank
			ys = (ty < oB) && (ty + 16 > oy);
			xc = (mx <= oR) && (mx + 8 >= ox);   // Inclusive for the missile
			yc = (my <= oB) && (my + 16 >= oy);
			if (i <= wallCount)
			begin
				case (keycode)
					keyUp:    s.tankBlocked |= (ty - 1 == oB) && xs;
					keyDown:  s.tankBlocked |= (ty + 17 == oy) && xs;
					keyLeft:  s.tankBlocked |= (tx - 1 == oR) && ys;
					keyRight: s.tankBlocked |= (tx + 17 == ox) && ys;
					default:  ;
				endcase
			end
			case (missileDir)
				dirUp:   hit = (my - 2 <= oB) && (my > oy) && xc;
				dirDown: hit = (my + 18 >= oy) && (my + 16 < oB) && xc;
				dirLeft: hit = (mx - 2 <= oR) && (mx > ox) && yc;
				default: hit = (mx + 10 >= ox) && (mx + 8 < oR) && yc;
			endcase
			rank = (i < wallCount) ? 1 : i - wallCount + 2;    // Wall, enemy, base
			if (hit && rank > best)
				best = rank;
		end
		s.hitKind = hitKindT'(best);
		return s;
	endfunction

	task automatic startTest(input string name);
		testName   = name;
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic endTest();
		$display("test %s: %0d checks, %0d errors", testName, testChecks, testErrors);
		totalChecks += testChecks;
		totalErrors += testErrors;
	endtask

	task automatic checkStatus(input statusT expected);
		testChecks++;
		assert (status == expected)
		else
		begin
			$display("[ERROR] %s expected %b actual %b", testName, expected, status);
			testErrors++;
		end
	endtask

	// Result is due one cycle after the inputs
	task automatic applyCheck();
		statusT expected;
		expected = expectStatus();
		@(posedge Clk);
		@(negedge Clk);
		checkStatus(expected);
	endtask

	// Registered status must not follow new inputs before the next edge
	task automatic checkHeld(input statusT previous);
		#25;
		checkStatus(previous);
	endtask

	// Status is unknown until the first edge in reset
	task automatic waitResetClear();
		int n;
		n = 0;
		while (status !== '0 && n < waitLimit)
		begin
			@(negedge Clk);
			n++;
		end
		if (status !== '0)
		begin
			$display("status was not cleared by reset within %0d cycles", waitLimit);
			testErrors++;
		end
	endtask

	task automatic quietInputs();
		keycode    = 8'h00;
		tankPos    = '{x: 10'd500, y: 10'd700};
		enemyPos   = '{x: 10'd900, y: 10'd900};
		walls[0]   = '{x: 10'd200, y: 10'd200, w: 10'd40, h: 10'd20};
		walls[1]   = '{x: 10'd600, y: 10'd600, w: 10'd20, h: 10'd20};
		walls[2]   = '{x: 10'd800, y: 10'd100, w: 10'd30, h: 10'd30};
		missilePos = '{x: 10'd50, y: 10'd800};
		missileDir = dirUp;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int tx;
		int ty;
		statusT held;
		totalChecks = 0;
		totalErrors = 0;
		rstN = 1'b0;
		quietInputs();

		// Inputs that would block and hit the base without reset
		startTest("reset");
		missilePos = '{x: 10'd124, y: 10'd257};
		tankPos    = '{x: 10'd210, y: 10'd221};
		keycode    = keyUp;
		waitResetClear();
		repeat (4)
		begin
			@(negedge Clk);
			checkStatus('0);
		end
		quietInputs();
		rstN = 1'b1;
		applyCheck();
		endTest();

		startTest("wallMove");
		for (int s = 0; s < 12; s++)
		begin
			tankPos = '{x: coordT'(spotX[s]), y: coordT'(spotY[s])};
			for (int k = 0; k < 5; k++)
			begin
				keycode = moveKeys[k];
				applyCheck();
			end
		end
		endTest();

		startTest("enemyMove");
		enemyPos = '{x: 10'd400, y: 10'd400};
		tankPos  = '{x: 10'd405, y: 10'd417};    // Flush below the enemy
		keycode  = keyUp;
		applyCheck();
		held     = expectStatus();
		keycode  = 8'h00;    // Must drop one cycle later
		checkHeld(held);
		applyCheck();
		tankPos  = '{x: 10'd383, y: 10'd395};    // Flush on its left
		keycode  = keyRight;
		applyCheck();
		endTest();

		// Wall only, wall plus enemy, then both stacked on the base
		startTest("missile");
		for (int d = 0; d < 4; d++)
		begin
			for (int s = 0; s < 3; s++)
			begin
				quietInputs();
				tx = (s == 2) ? int'(baseX) : 300;
				ty = (s == 2) ? int'(baseY) : 500;
				walls[1] = '{x: coordT'(tx), y: coordT'(ty), w: 10'd16, h: 10'd16};
				if (s > 0)
					enemyPos = '{x: coordT'(tx), y: coordT'(ty)};
				missileDir = dirT'(d);
				missilePos = '{x: coordT'(tx + missDx[d]), y: coordT'(ty + missDy[d])};
				applyCheck();
			end
		end
		endTest();

		startTest("random");
		for (int n = 0; n < 300; n++)
		begin
			for (int i = 0; i < wallCount; i++)
				walls[i] = '{x: randCoord(4, 940), y: randCoord(4, 940),
					w: randCoord(4, 56), h: randCoord(4, 56)};
			enemyPos = '{x: randCoord(40, 900), y: randCoord(40, 900)};
			tankPos  = '{x: randCoord(4, 980), y: randCoord(4, 980)};
			if (lcgNext() % 2 == 0)    // Tank close to the enemy
				tankPos = '{x: enemyPos.x + randCoord(0, 34) - 10'd17,
					y: enemyPos.y + randCoord(0, 34) - 10'd17};
			case (lcgNext() % 3)
				0: missilePos = '{x: randCoord(100, 150), y: randCoord(220, 270)};
				1: missilePos = '{x: enemyPos.x + randCoord(0, 40) - 10'd20,
					y: enemyPos.y + randCoord(0, 40) - 10'd20};
				default: missilePos = '{x: randCoord(4, 980), y: randCoord(4, 980)};
			endcase
			missileDir = dirT'(lcgNext() % 4);
			keycode = (lcgNext() % 6 == 5) ? 8'(lcgNext()) : moveKeys[lcgNext() % 5];
			applyCheck();
		end
		endTest();

		assertFails = i_dut.u_asserts.failCount;
		$display("total: %0d checks, %0d errors, %0d assertion failures", totalChecks,
			totalErrors, assertFails);
		if (totalErrors == 0 && assertFails == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin
		#(runLimit * 100);
		$display("watchdog expired after %0d cycles", runLimit);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/collisionTb_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module collisionTbAsserts
(
	input logic            Clk,
	input logic            rstN,
	input logic [7:0]      keycode,
	input tankPkg::pointT  missilePos,
	input tankPkg::statusT status
);
	import tankPkg::*;

	localparam int nearDist = 18;    // Pixels around the base

	int failCount = 0;    // Read by the testbench at the end

	function automatic logic isMoveKey(input logic [7:0] key);
		return (key == keyUp) || (key == keyDown) || (key == keyLeft) || (key == keyRight);
	endfunction

	// Base square grown by nearDist on every side
	function automatic logic nearBase(input pointT p);
		int px;
		int py;
		px = int'(p.x);
		py = int'(p.y);
		return (px >= int'(baseX) - nearDist) && (px <= int'(baseX) + int'(baseSize) + nearDist)
			&& (py >= int'(baseY) - nearDist) && (py <= int'(baseY) + int'(baseSize) + nearDist);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Status register properties
	//////////////////////////////////////////////////////////////////////

	resetClears: assert property (@(posedge Clk) !rstN |=> (status == '0))
	else
	begin
		$error("status not cleared while in reset");
		failCount++;
	end

	// A block needs a move key on the sampled cycle
	blockNeedsKey: assert property (@(posedge Clk) disable iff (!rstN)
		$rose(status.tankBlocked) |-> isMoveKey($past(keycode)))
	else
	begin
		$error("tankBlocked rose without a move key");
		failCount++;
	end

	baseNeedsNear: assert property (@(posedge Clk) disable iff (!rstN)
		(status.hitKind == hitBase) |-> nearBase($past(missilePos)))
	else
	begin
		$error("base hit reported with the missile far from the base");
		failCount++;
	end

endmodule

`default_nettype wire

/* hdl/collisionTop.sv */
`timescale 1ns/1ps
`default_nettype none

module collisionTop
(
	input  logic             Clk,
	input  logic             rstN,
	input  logic [7:0]       keycode,
	input  tankPkg::pointT   tankPos,
	input  tankPkg::pointT   enemyPos,
	input  tankPkg::wallSetT walls,
	input  tankPkg::pointT   missilePos,
	input  tankPkg::dirT     missileDir,
	output tankPkg::statusT  status
);
	import tankPkg::*;

	logic        blocked;    // Player move check, combinational
	missileHitsT hits;       // Unranked missile hit flags

	tankMoveCheck u_moveCheck
	(
		.keycode  (keycode),
		.tankPos  (tankPos),
		.enemyPos (enemyPos),
		.walls    (walls),
		.blocked  (blocked)
	);

	missileHitCheck u_hitCheck
	(
		.missilePos (missilePos),
		.missileDir (missileDir),
		.enemyPos   (enemyPos),
		.walls      (walls),
		.hits       (hits)
	);

	// Ranks the hits and registers everything
	hitArbiter u_arbiter
	(
		.Clk     (Clk),
		.rstN    (rstN),
		.blocked (blocked),
		.hits    (hits),
		.status  (status)
	);

endmodule

`default_nettype wire

/* hdl/hitArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module hitArbiter
(
	input  logic                 Clk,
	input  logic                 rstN,
	input  logic                 blocked,
	input  tankPkg::missileHitsT hits,
	output tankPkg::statusT      status
);
	import tankPkg::*;

	hitKindT nextKind;

	//////////////////////////////////////////////////////////////////////
	// Hit priority, base over enemy over wall
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (hits.baseHit)
		begin
			nextKind = hitBase;
		end
		else if (hits.enemyHit)
		begin
			nextKind = hitEnemy;
		end
		else if (hits.wallHit)
		begin
			nextKind = hitWall;
		end
		else
		begin
			nextKind = hitNone;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Status register, one cycle after the inputs
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			status.tankBlocked <= 1'b0;
			status.hitKind     <= hitNone;
		end
		else
		begin
			status.tankBlocked <= blocked;
			status.hitKind     <= nextKind;
		end
	end

endmodule

`default_nettype wire

/* hdl/missileHitCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module missileHitCheck
(
	input  tankPkg::pointT      missilePos,
	input  tankPkg::dirT        missileDir,
	input  tankPkg::pointT      enemyPos,
	input  tankPkg::wallSetT    walls,
	output tankPkg::missileHitsT hits
);
	import tankPkg::*;

	// Target order is walls, then enemy tank, then base
	localparam int enemyIdx    = wallCount;
	localparam int baseIdx     = wallCount + 1;
	localparam int targetCount = wallCount + 2;

	rectT [targetCount-1:0] targets;
	logic [targetCount-1:0] hitEach;

	cmpT mLeft;
	cmpT mTop;
	cmpT mRight;
	cmpT mBottom;
	cmpT nextTop;      // Top after one step up
	cmpT nextBottom;
	cmpT nextLeft;
	cmpT nextRight;

	//////////////////////////////////////////////////////////////////////
	// Missile box and its next step
	//////////////////////////////////////////////////////////////////////

	assign mLeft   = cmpT'(missilePos.x);
	assign mTop    = cmpT'(missilePos.y);
	assign mRight  = mLeft + cmpT'(missileWidth);
	assign mBottom = mTop + cmpT'(missileHeight);

	assign nextTop    = mTop - cmpT'(missileStep);
	assign nextBottom = mBottom + cmpT'(missileStep);    // y + 18
	assign nextLeft   = mLeft - cmpT'(missileStep);
	assign nextRight  = mRight + cmpT'(missileStep);     // x + 10

	assign targets[wallCount-1:0] = walls;
	assign targets[enemyIdx]      = makeSquare(enemyPos, tankSize);
	assign targets[baseIdx]       = baseRect;

	//////////////////////////////////////////////////////////////////////
	// Per target test for the current direction
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < targetCount; i++)
	begin : targetLoop
		cmpT tLeft;
		cmpT tTop;
		cmpT tRight;
		cmpT tBottom;
		logic xOverlap;
		logic yOverlap;
		logic hit;

		assign tLeft   = cmpT'(targets[i].x);
		assign tTop    = cmpT'(targets[i].y);
		assign tRight  = rectRight(targets[i]);
		assign tBottom = rectBottom(targets[i]);

		assign xOverlap = spanClosed(mLeft, mRight, tLeft, tRight);
		assign yOverlap = spanClosed(mTop, mBottom, tTop, tBottom);

		always_comb
		begin
			hit = 1'b0;
			case (missileDir)
				dirUp:
					hit = (nextTop <= tBottom) && (mTop > tTop) && xOverlap;
				dirDown:
					hit = (nextBottom >= tTop) && (mBottom < tBottom) && xOverlap;
				dirLeft:
					hit = (nextLeft <= tRight) && (mLeft > tLeft) && yOverlap;
				dirRight:
					hit = (nextRight >= tLeft) && (mRight < tRight) && yOverlap;
			endcase
		end

		assign hitEach[i] = hit;
	end

	// Classes reported side by side, ranking is done downstream
	assign hits.wallHit  = |hitEach[wallCount-1:0];
	assign hits.enemyHit = hitEach[enemyIdx];
	assign hits.baseHit  = hitEach[baseIdx];

endmodule

`default_nettype wire

/* hdl/tankMoveCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module tankMoveCheck
(
	input  logic [7:0]       keycode,
	input  tankPkg::pointT   tankPos,
	input  tankPkg::pointT   enemyPos,
	input  tankPkg::wallSetT walls,
	output logic             blocked
);
	import tankPkg::*;

	localparam int obstCount = wallCount + 1;    // Walls plus enemy tank

	rectT [obstCount-1:0] obstacles;
	logic [obstCount-1:0] hitEach;

	cmpT tankLeft;
	cmpT tankTop;
	cmpT tankRight;
	cmpT tankBottom;
	cmpT upEdge;      // Row the tank would reach going up
	cmpT downEdge;
	cmpT leftEdge;
	cmpT rightEdge;

	logic goUp;
	logic goDown;
	logic goLeft;
	logic goRight;

	//////////////////////////////////////////////////////////////////////
	// Key decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		goUp    = 1'b0;
		goDown  = 1'b0;
		goLeft  = 1'b0;
		goRight = 1'b0;
		case (keycode)
			keyUp:    goUp    = 1'b1;
			keyDown:  goDown  = 1'b1;
			keyLeft:  goLeft  = 1'b1;
			keyRight: goRight = 1'b1;
			default:  ;    // Other keys never block
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Tank box and next step edges
	//////////////////////////////////////////////////////////////////////

	assign tankLeft   = cmpT'(tankPos.x);
	assign tankTop    = cmpT'(tankPos.y);
	assign tankRight  = tankLeft + cmpT'(tankSize);
	assign tankBottom = tankTop + cmpT'(tankSize);

	assign upEdge    = tankTop - cmpT'(tankStep);
	assign downEdge  = tankBottom + cmpT'(tankStep);    // y + 17
	assign leftEdge  = tankLeft - cmpT'(tankStep);
	assign rightEdge = tankRight + cmpT'(tankStep);

	assign obstacles[wallCount-1:0] = walls;
	assign obstacles[wallCount]     = makeSquare(enemyPos, tankSize);

	// One edge test per obstacle
	for (genvar i = 0; i < obstCount; i++)
	begin : obstLoop
		cmpT oLeft;
		cmpT oTop;
		cmpT oRight;
		cmpT oBottom;
		logic xOverlap;
		logic yOverlap;

		assign oLeft   = cmpT'(obstacles[i].x);
		assign oTop    = cmpT'(obstacles[i].y);
		assign oRight  = rectRight(obstacles[i]);
		assign oBottom = rectBottom(obstacles[i]);

		assign xOverlap = spanOpen(tankLeft, tankRight, oLeft, oRight);
		assign yOverlap = spanOpen(tankTop, tankBottom, oTop, oBottom);

		assign hitEach[i] = (goUp    && (upEdge == oBottom)   && xOverlap)
			|| (goDown  && (downEdge == oTop)    && xOverlap)
			|| (goLeft  && (leftEdge == oRight)  && yOverlap)
			|| (goRight && (rightEdge == oLeft)  && yOverlap);
	end

	assign blocked = |hitEach;

endmodule

`default_nettype wire

/* hdl/tankPkg.sv */
`default_nettype none

package tankPkg;

	//////////////////////////////////////////////////////////////////////
	// Field and object geometry
	//////////////////////////////////////////////////////////////////////

	localparam int coordW    = 10;
	localparam int cmpW      = 11;    // One spare bit so sums never wrap
	localparam int wallCount = 3;

	typedef logic [coordW-1:0] coordT;
	typedef logic [cmpW-1:0]   cmpT;

	localparam coordT tankSize      = 10'd16;
	localparam coordT tankStep      = 10'd1;
	localparam coordT missileWidth  = 10'd8;
	localparam coordT missileHeight = 10'd16;
	localparam coordT missileStep   = 10'd2;

	// Fixed base square
	localparam coordT baseX    = 10'd120;
	localparam coordT baseY    = 10'd240;
	localparam coordT baseSize = 10'd16;

	// Keyboard make codes
	localparam logic [7:0] keyUp    = 8'h1d;
	localparam logic [7:0] keyDown  = 8'h1b;
	localparam logic [7:0] keyLeft  = 8'h1c;
	localparam logic [7:0] keyRight = 8'h23;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {dirUp = 2'b00, dirLeft = 2'b01, dirDown = 2'b10,
		dirRight = 2'b11} dirT;

	typedef struct packed {
		coordT x;
		coordT y;
		coordT w;
		coordT h;
	} rectT;

	typedef rectT [wallCount-1:0] wallSetT;

	typedef struct packed {
		coordT x;
		coordT y;
	} pointT;

	typedef enum logic [1:0] {hitNone, hitWall, hitEnemy, hitBase} hitKindT;

	typedef struct packed {
		logic wallHit;
		logic enemyHit;
		logic baseHit;
	} missileHitsT;

	typedef struct packed {
		logic    tankBlocked;
		hitKindT hitKind;
	} statusT;

	localparam rectT baseRect = '{x: baseX, y: baseY, w: baseSize, h: baseSize};

	//////////////////////////////////////////////////////////////////////
	// Helpers shared by both checkers
	//////////////////////////////////////////////////////////////////////

	// Square of given side with its top left corner at a point
	function automatic rectT makeSquare(input pointT corner, input coordT side);
		rectT sq;
		sq.x = corner.x;
		sq.y = corner.y;
		sq.w = side;
		sq.h = side;
		return sq;
	endfunction

	function automatic cmpT rectRight(input rectT r);
		return cmpT'(r.x) + cmpT'(r.w);
	endfunction

	function automatic cmpT rectBottom(input rectT r);
		return cmpT'(r.y) + cmpT'(r.h);
	endfunction

	// Strict overlap, touching edges do not count
	function automatic logic spanOpen(input cmpT aStart, input cmpT aEnd,
		input cmpT bStart, input cmpT bEnd);
		return (aStart < bEnd) && (aEnd > bStart);
	endfunction

	// Inclusive overlap
	function automatic logic spanClosed(input cmpT aStart, input cmpT aEnd,
		input cmpT bStart, input cmpT bEnd);
		return (aStart <= bEnd) && (aEnd >= bStart);
	endfunction

endpackage

`default_nettype wire
